/* hdl/axil_csr_slave.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

module axil_csr_slave
  ( input  logic                                   aclk
  , input  logic                                   arst_n_i
  , input  logic [`ZS_AXIL_ADDR_W-1:0]             awaddr_i
  , input  logic                                   awvalid_i
  , output logic                                   awready_o
  , input  logic [`ZS_AXIL_DATA_W-1:0]             wdata_i
  , input  logic [`ZS_AXIL_DATA_W/8-1:0]           wstrb_i
  , input  logic                                   wvalid_i
  , output logic                                   wready_o
  , output zynq_shell_pkg::axil_resp_e             bresp_o
  , output logic                                   bvalid_o
  , input  logic                                   bready_i
  , input  logic [`ZS_AXIL_ADDR_W-1:0]             araddr_i
  , input  logic                                   arvalid_i
  , output logic                                   arready_o
  , output logic [`ZS_AXIL_DATA_W-1:0]             rdata_o
  , output zynq_shell_pkg::axil_resp_e             rresp_o
  , output logic                                   rvalid_o
  , input  logic                                   rready_i
  , output logic [`ZS_AXIL_DATA_W-1:0]             tx_data_o
  , output logic                                   tx_valid_o
  , input  logic                                   tx_ready_i
  , input  logic [$clog2(`ZS_FIFO_DEPTH+1)-1:0]    tx_count_i
  , input  logic [`ZS_AXIL_DATA_W-1:0]             rx_data_i
  , input  logic                                   rx_valid_i
  , output logic                                   rx_ready_o
  , input  logic [$clog2(`ZS_FIFO_DEPTH+1)-1:0]    rx_count_i
  , output zynq_dram_pkg::hp_addr_t                dram_base_o
  );

  import zynq_shell_pkg::*;
  import zynq_dram_pkg::*;

  localparam int DATA_W = `ZS_AXIL_DATA_W;
  localparam int ROM_AW = $clog2(`ZS_ROM_ELS);

  axil_state_e       wr_state_q;
  axil_state_e       rd_state_q;
  axil_resp_e        bresp_q;
  axil_resp_e        rresp_q;
  axil_resp_e        rd_resp;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] rom_addr_q;
  logic [DATA_W-1:0] rom_word;
  hp_addr_t          dram_base_q;
  logic              wr_fire;
  logic              rd_fire;

  function automatic logic [DATA_W-1:0] merge_bytes
    ( input logic [DATA_W-1:0]   old_val
    , input logic [DATA_W-1:0]   new_val
    , input logic [DATA_W/8-1:0] strb
    );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < DATA_W/8; b++)
    begin
      if (strb[b])
      begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // write channel

  // aw and w are taken together in one cycle
  assign wr_fire   = (wr_state_q == ST_IDLE) && awvalid_i && wvalid_i;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign bvalid_o  = (wr_state_q == ST_RESP);
  assign bresp_o   = bresp_q;

  // no push when full, the write gets SLVERR instead
  assign tx_valid_o  = wr_fire && (awaddr_i == CSR_TX_FIFO) && tx_ready_i;
  assign tx_data_o   = wdata_i;
  assign dram_base_o = dram_base_q;

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_state_q  <= ST_IDLE;
      bresp_q     <= RESP_OKAY;
      dram_base_q <= '0;
      rom_addr_q  <= '0;
    end
    else if (wr_fire)
    begin
      wr_state_q <= ST_RESP;
      bresp_q    <= RESP_OKAY;
      case (awaddr_i)
        CSR_DRAM_BASE: dram_base_q <= merge_bytes(dram_base_q, wdata_i, wstrb_i);
        CSR_ROM_ADDR:  rom_addr_q  <= merge_bytes(rom_addr_q, wdata_i, wstrb_i);
        CSR_TX_FIFO:   bresp_q     <= tx_ready_i ? RESP_OKAY : RESP_SLVERR;
        default:       ;
      endcase
    end
    else if (bvalid_o && bready_i)
    begin
      wr_state_q <= ST_IDLE;
    end
  end

  //////////////////////////////////////////////////
  // read channel

  assign rd_fire    = (rd_state_q == ST_IDLE) && arvalid_i;
  assign arready_o  = (rd_state_q == ST_IDLE);
  assign rvalid_o   = (rd_state_q == ST_RESP);
  assign rdata_o    = rdata_q;
  assign rresp_o    = rresp_q;
  assign rx_ready_o = rd_fire && (araddr_i == CSR_RX_FIFO);

  // words past the end of the rom read as zero
  assign rom_word = (rom_addr_q < `ZS_ROM_ELS) ? config_rom_c[rom_addr_q[ROM_AW-1:0]] : '0;

  always_comb
  begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (araddr_i)
      CSR_DRAM_BASE: rd_data = dram_base_q;
      CSR_ROM_ADDR:  rd_data = rom_addr_q;
      CSR_ROM_DATA:  rd_data = rom_word;
      CSR_RX_FIFO:
      begin
        rd_data = rx_valid_i ? rx_data_i : '0;
        rd_resp = rx_valid_i ? RESP_OKAY : RESP_SLVERR;
      end
      CSR_TX_FREE:   rd_data = DATA_W'(`ZS_FIFO_DEPTH) - DATA_W'(tx_count_i);
      CSR_RX_COUNT:  rd_data = DATA_W'(rx_count_i);
      default:       ;
    endcase
  end

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_state_q <= ST_IDLE;
      rresp_q    <= RESP_OKAY;
    end
    else if (rd_fire)
    begin
      rd_state_q <= ST_RESP;
      rresp_q    <= rd_resp;
    end
    else if (rvalid_o && rready_i)
    begin
      rd_state_q <= ST_IDLE;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rd_fire)
    begin
      rdata_q <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/dram_addr_remap.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

module dram_addr_remap
  ( input  logic                     aclk
  , input  logic                     arst_n_i
  , input  zynq_dram_pkg::llc_addr_t dma_addr_i
  , input  zynq_dram_pkg::cache_id_t dma_cache_id_i
  , input  logic                     dma_valid_i
  , output logic                     dma_ready_o
  , input  zynq_dram_pkg::hp_addr_t  dram_base_i
  , output zynq_dram_pkg::hp_addr_t  hp0_addr_o
  , output logic                     hp0_valid_o
  , input  logic                     hp0_ready_i
  );

  import zynq_dram_pkg::*;

  // line address bits left below the cache id
  localparam int LOW_W = `ZS_LLC_ADDR_W - `ZS_CACHE_ID_W;

  llc_addr_t packed_addr;
  hp_addr_t  hp0_addr_q;
  logic      hp0_valid_q;
  logic      accept;

  assign packed_addr = {dma_cache_id_i, dma_addr_i[LOW_W-1:0]};

  // slot is free when empty or drained this cycle
  assign dma_ready_o = !hp0_valid_q || hp0_ready_i;
  assign accept      = dma_valid_i && dma_ready_o;
  assign hp0_addr_o  = hp0_addr_q;
  assign hp0_valid_o = hp0_valid_q;

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hp0_valid_q <= 1'b0;
    end
    else if (dma_ready_o)
    begin
      hp0_valid_q <= dma_valid_i;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept)
    begin
      hp0_addr_q <= hp_addr_t'(packed_addr) + dram_base_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/pl_fifo.sv */
`default_nettype none

module pl_fifo
  #( parameter int DEPTH = 4
   , parameter int WIDTH = 32
   )
  ( input  logic                       aclk
  , input  logic                       arst_n_i
  , input  logic [WIDTH-1:0]           in_data_i
  , input  logic                       in_valid_i
  , output logic                       in_ready_o
  , output logic [WIDTH-1:0]           out_data_o
  , output logic                       out_valid_o
  , input  logic                       out_ready_i
  , output logic [$clog2(DEPTH+1)-1:0] count_o
  );

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign count_o     = count_q;
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop)
      begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // count only moves when one side fires alone
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/zynq_dram_pkg.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

package zynq_dram_pkg;

  // address of one cache line as seen by the dma side
  typedef logic [`ZS_LLC_ADDR_W-1:0] llc_addr_t;

  // which last level cache issued the request
  typedef logic [`ZS_CACHE_ID_W-1:0] cache_id_t;

  // byte address on the hp0 port
  typedef logic [`ZS_HP_ADDR_W-1:0] hp_addr_t;

endpackage

`default_nettype wire

/* hdl/zynq_shell_pkg.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

package zynq_shell_pkg;

  // byte addresses on gp0
  typedef enum logic [`ZS_AXIL_ADDR_W-1:0] {
    CSR_DRAM_BASE = 10'h000,
    CSR_ROM_ADDR  = 10'h004,
    CSR_ROM_DATA  = 10'h008,
    CSR_TX_FIFO   = 10'h00C,
    CSR_RX_FIFO   = 10'h010,
    CSR_TX_FREE   = 10'h014,
    CSR_RX_COUNT  = 10'h018
  } csr_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axil_resp_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } axil_state_e;

  // machine description: version, pod geometry, cache shape, fifo info
  localparam logic [`ZS_AXIL_DATA_W-1:0] config_rom_c [`ZS_ROM_ELS] = '{
    32'h0004_0001, 32'h0000_0010, 32'h0000_0008, 32'h0000_0004,
    32'h0000_0040, 32'h0000_0008, 32'h0000_0004, 32'hC0DE_5E11
  };

endpackage

`default_nettype wire

/* hdl/zynq_shell_top.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

module zynq_shell_top
  ( input  logic                             aclk
  , input  logic                             arst_n_i
  , input  logic [`ZS_AXIL_ADDR_W-1:0]       gp0_axi_awaddr_i
  , input  logic                             gp0_axi_awvalid_i
  , output logic                             gp0_axi_awready_o
  , input  logic [`ZS_AXIL_DATA_W-1:0]       gp0_axi_wdata_i
  , input  logic [`ZS_AXIL_DATA_W/8-1:0]     gp0_axi_wstrb_i
  , input  logic                             gp0_axi_wvalid_i
  , output logic                             gp0_axi_wready_o
  , output zynq_shell_pkg::axil_resp_e       gp0_axi_bresp_o
  , output logic                             gp0_axi_bvalid_o
  , input  logic                             gp0_axi_bready_i
  , input  logic [`ZS_AXIL_ADDR_W-1:0]       gp0_axi_araddr_i
  , input  logic                             gp0_axi_arvalid_i
  , output logic                             gp0_axi_arready_o
  , output logic [`ZS_AXIL_DATA_W-1:0]       gp0_axi_rdata_o
  , output zynq_shell_pkg::axil_resp_e       gp0_axi_rresp_o
  , output logic                             gp0_axi_rvalid_o
  , input  logic                             gp0_axi_rready_i
  , output logic [`ZS_AXIL_DATA_W-1:0]       host_req_data_o
  , output logic                             host_req_valid_o
  , input  logic                             host_req_ready_i
  , input  logic [`ZS_AXIL_DATA_W-1:0]       pl_req_data_i
  , input  logic                             pl_req_valid_i
  , output logic                             pl_req_ready_o
  , input  zynq_dram_pkg::llc_addr_t         dma_addr_i
  , input  zynq_dram_pkg::cache_id_t         dma_cache_id_i
  , input  logic                             dma_valid_i
  , output logic                             dma_ready_o
  , output zynq_dram_pkg::hp_addr_t          hp0_addr_o
  , output logic                             hp0_valid_o
  , input  logic                             hp0_ready_i
  );

  import zynq_dram_pkg::*;

  localparam int CNT_W = $clog2(`ZS_FIFO_DEPTH + 1);

  logic [`ZS_AXIL_DATA_W-1:0] tx_push_data;
  logic                       tx_push_valid;
  logic                       tx_push_ready;
  logic [CNT_W-1:0]           tx_count;
  logic [`ZS_AXIL_DATA_W-1:0] rx_pop_data;
  logic                       rx_pop_valid;
  logic                       rx_pop_ready;
  logic [CNT_W-1:0]           rx_count;
  hp_addr_t                   dram_base;

  //////////////////////////////////////////////////
  // gp0 control registers

  axil_csr_slave csr_i
    ( .aclk        (aclk)
    , .arst_n_i    (arst_n_i)
    , .awaddr_i    (gp0_axi_awaddr_i)
    , .awvalid_i   (gp0_axi_awvalid_i)
    , .awready_o   (gp0_axi_awready_o)
    , .wdata_i     (gp0_axi_wdata_i)
    , .wstrb_i     (gp0_axi_wstrb_i)
    , .wvalid_i    (gp0_axi_wvalid_i)
    , .wready_o    (gp0_axi_wready_o)
    , .bresp_o     (gp0_axi_bresp_o)
    , .bvalid_o    (gp0_axi_bvalid_o)
    , .bready_i    (gp0_axi_bready_i)
    , .araddr_i    (gp0_axi_araddr_i)
    , .arvalid_i   (gp0_axi_arvalid_i)
    , .arready_o   (gp0_axi_arready_o)
    , .rdata_o     (gp0_axi_rdata_o)
    , .rresp_o     (gp0_axi_rresp_o)
    , .rvalid_o    (gp0_axi_rvalid_o)
    , .rready_i    (gp0_axi_rready_i)
    , .tx_data_o   (tx_push_data)
    , .tx_valid_o  (tx_push_valid)
    , .tx_ready_i  (tx_push_ready)
    , .tx_count_i  (tx_count)
    , .rx_data_i   (rx_pop_data)
    , .rx_valid_i  (rx_pop_valid)
    , .rx_ready_o  (rx_pop_ready)
    , .rx_count_i  (rx_count)
    , .dram_base_o (dram_base)
    );

  //////////////////////////////////////////////////
  // host <-> pl streams

  pl_fifo #(.DEPTH(`ZS_FIFO_DEPTH), .WIDTH(`ZS_AXIL_DATA_W)) tx_fifo_i
    ( .aclk        (aclk)
    , .arst_n_i    (arst_n_i)
    , .in_data_i   (tx_push_data)
    , .in_valid_i  (tx_push_valid)
    , .in_ready_o  (tx_push_ready)
    , .out_data_o  (host_req_data_o)
    , .out_valid_o (host_req_valid_o)
    , .out_ready_i (host_req_ready_i)
    , .count_o     (tx_count)
    );

  pl_fifo #(.DEPTH(`ZS_FIFO_DEPTH), .WIDTH(`ZS_AXIL_DATA_W)) rx_fifo_i
    ( .aclk        (aclk)
    , .arst_n_i    (arst_n_i)
    , .in_data_i   (pl_req_data_i)
    , .in_valid_i  (pl_req_valid_i)
    , .in_ready_o  (pl_req_ready_o)
    , .out_data_o  (rx_pop_data)
    , .out_valid_o (rx_pop_valid)
    , .out_ready_i (rx_pop_ready)
    , .count_o     (rx_count)
    );

  // cache dma addresses onto hp0
  dram_addr_remap remap_i
    ( .aclk           (aclk)
    , .arst_n_i       (arst_n_i)
    , .dma_addr_i     (dma_addr_i)
    , .dma_cache_id_i (dma_cache_id_i)
    , .dma_valid_i    (dma_valid_i)
    , .dma_ready_o    (dma_ready_o)
    , .dram_base_i    (dram_base)
    , .hp0_addr_o     (hp0_addr_o)
    , .hp0_valid_o    (hp0_valid_o)
    , .hp0_ready_i    (hp0_ready_i)
    );

endmodule

`default_nettype wire

/* include/zynq_shell_macros.svh */
`ifndef ZYNQ_SHELL_MACROS_SVH
`define ZYNQ_SHELL_MACROS_SVH

// gp0 axi-lite control port
`define ZS_AXIL_ADDR_W 10
`define ZS_AXIL_DATA_W 32

// host and pl stream fifos
`define ZS_FIFO_DEPTH 4

// machine description rom
`define ZS_ROM_ELS 8

// dram address path
`define ZS_LLC_ADDR_W 28
`define ZS_CACHE_ID_W 3
`define ZS_HP_ADDR_W 32

`endif

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_zynq_shell
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_zynq_shell -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  exit 0
fi
exit 1

/* verif/tb_zynq_shell.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

module tb_zynq_shell;

  import zynq_shell_pkg::*;
  import zynq_dram_pkg::*;

  localparam int          CLK_PERIOD = 10;
  localparam int          NUM_REMAP  = 50;
  localparam logic [31:0] SEED       = 32'h6541_1504;
  // about 40 cycles per remap item covers every test with margin
  localparam int          TIMEOUT    = 40 * NUM_REMAP * CLK_PERIOD;

  logic                             aclk = 1'b0;
  logic                             arst_n_i;
  logic [`ZS_AXIL_ADDR_W-1:0]       gp0_axi_awaddr_i;
  logic                             gp0_axi_awvalid_i;
  logic                             gp0_axi_awready_o;
  logic [`ZS_AXIL_DATA_W-1:0]       gp0_axi_wdata_i;
  logic [`ZS_AXIL_DATA_W/8-1:0]     gp0_axi_wstrb_i;
  logic                             gp0_axi_wvalid_i;
  logic                             gp0_axi_wready_o;
  axil_resp_e                       gp0_axi_bresp_o;
  logic                             gp0_axi_bvalid_o;
  logic                             gp0_axi_bready_i;
  logic [`ZS_AXIL_ADDR_W-1:0]       gp0_axi_araddr_i;
  logic                             gp0_axi_arvalid_i;
  logic                             gp0_axi_arready_o;
  logic [`ZS_AXIL_DATA_W-1:0]       gp0_axi_rdata_o;
  axil_resp_e                       gp0_axi_rresp_o;
  logic                             gp0_axi_rvalid_o;
  logic                             gp0_axi_rready_i;
  logic [`ZS_AXIL_DATA_W-1:0]       host_req_data_o;
  logic                             host_req_valid_o;
  logic                             host_req_ready_i;
  logic [`ZS_AXIL_DATA_W-1:0]       pl_req_data_i;
  logic                             pl_req_valid_i;
  logic                             pl_req_ready_o;
  llc_addr_t                        dma_addr_i;
  cache_id_t                        dma_cache_id_i;
  logic                             dma_valid_i;
  logic                             dma_ready_o;
  hp_addr_t                         hp0_addr_o;
  logic                             hp0_valid_o;
  logic                             hp0_ready_i = 1'b0;

  logic [31:0] stim_rng = SEED;
  logic [31:0] ready_rng = SEED;
  logic        rand_hp0_ready = 1'b0;
  int          cycle_cnt = 0;
  int          hp0_seen = 0;
  int          error_count = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name;
  hp_addr_t    hp0_expect_q[$];
  int          hp0_accept_q[$];

  zynq_shell_top dut_i (.*);

  bind zynq_shell_top zynq_shell_assertions assertions_i
    ( .aclk             (aclk)
    , .arst_n_i         (arst_n_i)
    , .bvalid_i         (gp0_axi_bvalid_o)
    , .bready_i         (gp0_axi_bready_i)
    , .rvalid_i         (gp0_axi_rvalid_o)
    , .rready_i         (gp0_axi_rready_i)
    , .rdata_i          (gp0_axi_rdata_o)
    , .hp0_valid_i      (hp0_valid_o)
    , .hp0_ready_i      (hp0_ready_i)
    , .hp0_addr_i       (hp0_addr_o)
    , .host_req_valid_i (host_req_valid_o)
    , .host_req_ready_i (host_req_ready_i)
    , .tx_push_valid_i  (tx_push_valid)
    , .tx_push_ready_i  (tx_push_ready)
    );

  always #(CLK_PERIOD/2) aclk = ~aclk;

  always @(posedge aclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    stim_rng = lcg_step(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = next_random();
    return r[24];
  endfunction

  // cache id sits on bits 27:25, the line keeps bits 24:0
  function automatic hp_addr_t ref_hp0_addr
    ( input llc_addr_t line
    , input cache_id_t id
    , input hp_addr_t  base
    );
    logic [31:0] offset;
    offset = (32'(id) << 25) | (32'(line) & 32'h01FF_FFFF);
    return offset + base;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count != errors_at_start)
    begin
      tests_failed++;
      $display("test %s: FAIL", test_name);
    end
    else
    begin
      $display("test %s: pass", test_name);
    end
  endtask

  task automatic idle_gap();
    repeat (next_random() % 3) @(posedge aclk);
  endtask

  //////////////////////////////////////////////////
  // bus and stream drivers

  task automatic axil_write(input logic [9:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    logic done;
    idle_gap();
    @(posedge aclk);
    #1;
    gp0_axi_awaddr_i  = addr;
    gp0_axi_wdata_i   = data;
    gp0_axi_wstrb_i   = strb;
    gp0_axi_awvalid_i = 1'b1;
    gp0_axi_wvalid_i  = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge aclk);
      done = gp0_axi_awready_o && gp0_axi_wready_o;
      @(posedge aclk);
      #1;
    end
    gp0_axi_awvalid_i = 1'b0;
    gp0_axi_wvalid_i  = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      gp0_axi_bready_i = random_bit();
      @(negedge aclk);
      done = gp0_axi_bvalid_o && gp0_axi_bready_i;
      resp = gp0_axi_bresp_o;
      @(posedge aclk);
      #1;
    end
    gp0_axi_bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [9:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    logic done;
    idle_gap();
    @(posedge aclk);
    #1;
    gp0_axi_araddr_i  = addr;
    gp0_axi_arvalid_i = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge aclk);
      done = gp0_axi_arready_o;
      @(posedge aclk);
      #1;
    end
    gp0_axi_arvalid_i = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      gp0_axi_rready_i = random_bit();
      @(negedge aclk);
      done = gp0_axi_rvalid_o && gp0_axi_rready_i;
      data = gp0_axi_rdata_o;
      resp = gp0_axi_rresp_o;
      @(posedge aclk);
      #1;
    end
    gp0_axi_rready_i = 1'b0;
  endtask

  task automatic pl_send(input logic [31:0] data);
    logic done;
    @(posedge aclk);
    #1;
    pl_req_data_i  = data;
    pl_req_valid_i = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge aclk);
      done = pl_req_ready_o;
      @(posedge aclk);
      #1;
    end
    pl_req_valid_i = 1'b0;
  endtask

  // hp0 back-pressure
  always @(posedge aclk)
  begin
    #1;
    ready_rng = lcg_step(ready_rng);
    hp0_ready_i = rand_hp0_ready && ready_rng[23];
  end

  // compares every hp0 transfer against the expected queue
  always @(negedge aclk)
  begin
    hp_addr_t exp_addr;
    int       acc_cyc;
    if (arst_n_i && hp0_valid_o && hp0_ready_i)
    begin
      if (hp0_expect_q.size() == 0)
      begin
        $display("hp0 transfer at %0t with no address pending", $time);
        error_count++;
      end
      else
      begin
        exp_addr = hp0_expect_q.pop_front();
        acc_cyc  = hp0_accept_q.pop_front();
        check_value(hp0_addr_o, exp_addr, "hp0 address");
        if (cycle_cnt <= acc_cyc)
        begin
          $display("hp0 address at %0t came out in its own accept cycle", $time);
          error_count++;
        end
      end
      hp0_seen++;
    end
  end

  //////////////////////////////////////////////////
  // tests

  initial
  begin
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] rnd;
    hp_addr_t    base;
    int          got;
    logic        done;
    arst_n_i          = 1'b0;
    gp0_axi_awaddr_i  = '0;
    gp0_axi_awvalid_i = 1'b0;
    gp0_axi_wdata_i   = '0;
    gp0_axi_wstrb_i   = '0;
    gp0_axi_wvalid_i  = 1'b0;
    gp0_axi_bready_i  = 1'b0;
    gp0_axi_araddr_i  = '0;
    gp0_axi_arvalid_i = 1'b0;
    gp0_axi_rready_i  = 1'b0;
    host_req_ready_i  = 1'b0;
    pl_req_data_i     = '0;
    pl_req_valid_i    = 1'b0;
    dma_addr_i        = '0;
    dma_cache_id_i    = '0;
    dma_valid_i       = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    arst_n_i = 1'b1;

    begin_test("reset state");
    @(negedge aclk);
    check_value(gp0_axi_bvalid_o, 1'b0, "bvalid after reset");
    check_value(gp0_axi_rvalid_o, 1'b0, "rvalid after reset");
    check_value(host_req_valid_o, 1'b0, "host_req_valid_o after reset");
    check_value(hp0_valid_o, 1'b0, "hp0_valid_o after reset");
    axil_read(CSR_DRAM_BASE, data, resp);
    check_value(data, 32'h0, "dram base after reset");
    axil_read(CSR_TX_FREE, data, resp);
    check_value(data, `ZS_FIFO_DEPTH, "tx free after reset");
    axil_read(CSR_RX_COUNT, data, resp);
    check_value(data, 32'h0, "rx count after reset");
    end_test();

    begin_test("registers and rom");
    axil_write(CSR_DRAM_BASE, 32'h1122_3344, 4'hF, resp);
    axil_write(CSR_DRAM_BASE, 32'hAABB_CCDD, 4'b0101, resp);
    check_value(resp, RESP_OKAY, "partial write response");
    axil_read(CSR_DRAM_BASE, data, resp);
    check_value(data, 32'h11BB_33DD, "dram base after partial write");
    for (int a = 0; a < 10; a++)
    begin
      axil_write(CSR_ROM_ADDR, a, 4'hF, resp);
      axil_read(CSR_ROM_DATA, data, resp);
      check_value(data, (a < `ZS_ROM_ELS) ? config_rom_c[a] : 32'h0,
                  $sformatf("rom word %0d", a));
    end
    axil_write(10'h020, 32'hFFFF_FFFF, 4'hF, resp);
    check_value(resp, RESP_OKAY, "unmapped write response");
    axil_read(10'h020, data, resp);
    check_value(data, 32'h0, "unmapped read data");
    check_value(resp, RESP_OKAY, "unmapped read response");
    end_test();

    begin_test("host to pl fifo");
    for (int i = 0; i < 5; i++)
    begin
      axil_write(CSR_TX_FIFO, 32'hA000_0000 + i, 4'hF, resp);
      check_value(resp, (i < `ZS_FIFO_DEPTH) ? RESP_OKAY : RESP_SLVERR,
                  $sformatf("tx write %0d response", i));
    end
    got = 0;
    while (got < `ZS_FIFO_DEPTH)
    begin
      @(posedge aclk);
      #1;
      host_req_ready_i = random_bit();
      @(negedge aclk);
      if (host_req_valid_o && host_req_ready_i)
      begin
        check_value(host_req_data_o, 32'hA000_0000 + got, "host stream word");
        got++;
      end
    end
    @(posedge aclk);
    #1;
    host_req_ready_i = 1'b0;
    @(negedge aclk);
    check_value(host_req_valid_o, 1'b0, "host stream valid after drain");
    axil_read(CSR_TX_FREE, data, resp);
    check_value(data, `ZS_FIFO_DEPTH, "tx free after drain");
    end_test();

    begin_test("pl to host fifo");
    for (int i = 0; i < 3; i++)
    begin
      pl_send(32'h5000_0001 + i);
    end
    axil_read(CSR_RX_COUNT, data, resp);
    check_value(data, 32'd3, "rx count");
    for (int i = 0; i < 3; i++)
    begin
      axil_read(CSR_RX_FIFO, data, resp);
      check_value(data, 32'h5000_0001 + i, "rx fifo word");
      check_value(resp, RESP_OKAY, "rx fifo read response");
    end
    axil_read(CSR_RX_FIFO, data, resp);
    check_value(data, 32'h0, "empty rx fifo data");
    check_value(resp, RESP_SLVERR, "empty rx fifo response");
    end_test();

    begin_test("address remap");
    // high base so some sums wrap past 2^32
    base = 32'hF123_4560;
    axil_write(CSR_DRAM_BASE, base, 4'hF, resp);
    rand_hp0_ready = 1'b1;
    @(posedge aclk);
    #1;
    for (int i = 0; i < NUM_REMAP; i++)
    begin
      if (random_bit() && random_bit())
      begin
        dma_valid_i = 1'b0;
        @(posedge aclk);
        #1;
      end
      rnd = next_random();
      dma_addr_i = rnd[27:0];
      rnd = next_random();
      dma_cache_id_i = rnd[2:0];
      dma_valid_i = 1'b1;
      done = 1'b0;
      while (!done)
      begin
        @(negedge aclk);
        done = dma_ready_o;
        if (done)
        begin
          hp0_expect_q.push_back(ref_hp0_addr(dma_addr_i, dma_cache_id_i, base));
          hp0_accept_q.push_back(cycle_cnt);
        end
        @(posedge aclk);
        #1;
      end
    end
    dma_valid_i = 1'b0;
    while (hp0_seen < NUM_REMAP)
    begin
      @(posedge aclk);
    end
    rand_hp0_ready = 1'b0;
    repeat (3) @(posedge aclk);
    check_value(hp0_seen, NUM_REMAP, "hp0 transfer count");
    check_value(hp0_expect_q.size(), 0, "hp0 addresses left over");
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

  initial
  begin
    #(TIMEOUT);
    $display("watchdog expired at %0t, a handshake never completed", $time);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/zynq_shell_assertions.sv */
`default_nettype none

`include "zynq_shell_macros.svh"

module zynq_shell_assertions
  ( input logic                                 aclk
  , input logic                                 arst_n_i
  , input logic                                 bvalid_i
  , input logic                                 bready_i
  , input logic                                 rvalid_i
  , input logic                                 rready_i
  , input logic [`ZS_AXIL_DATA_W-1:0]           rdata_i
  , input logic                                 hp0_valid_i
  , input logic                                 hp0_ready_i
  , input logic [`ZS_HP_ADDR_W-1:0]             hp0_addr_i
  , input logic                                 host_req_valid_i
  , input logic                                 host_req_ready_i
  , input logic                                 tx_push_valid_i
  , input logic                                 tx_push_ready_i
  );

  logic [$clog2(`ZS_FIFO_DEPTH+1)-1:0] tx_level_q;

  // tx fifo occupancy rebuilt from its push and pop handshakes
  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tx_level_q <= '0;
    end
    else
    begin
      tx_level_q <= tx_level_q + (tx_push_valid_i && tx_push_ready_i)
                               - (host_req_valid_i && host_req_ready_i);
    end
  end

  // write response waits for the master
  bvalid_hold_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid or rdata changed before rready");

  // stalled hp0 address is held
  hp0_stable_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    hp0_valid_i && !hp0_ready_i |=> hp0_valid_i && $stable(hp0_addr_i))
    else $error("hp0 address changed while stalled");

  host_req_empty_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    !(host_req_valid_i && (tx_level_q == '0)))
    else $error("host_req_valid_o high with the tx fifo empty");

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/zynq_shell_pkg.sv
hdl/zynq_dram_pkg.sv
hdl/axil_csr_slave.sv
hdl/pl_fifo.sv
hdl/dram_addr_remap.sv
hdl/zynq_shell_top.sv
verif/zynq_shell_assertions.sv
verif/tb_zynq_shell.sv
